// File: include/snake_cfg.svh
`ifndef SNAKE_CFG_SVH
`define SNAKE_CFG_SVH

// Playing field in cells
`define GRID_COLS 24
`define GRID_ROWS 19
`define CELL_PX 25
`define FIELD_ORG_PX 3

// Wall pixel limits
`define WALL_LEFT_MAX 2
`define WALL_RIGHT_MIN 602
`define WALL_RIGHT_MAX 604
`define WALL_TOP_MAX 2
`define WALL_BOTTOM_MIN 477
`define WALL_BOTTOM_MAX 479

`define MAX_SEGMENTS 15

// Clocks per step, slowest first
`define STEP_PERIOD_0 40
`define STEP_PERIOD_1 28
`define STEP_PERIOD_2 18
`define STEP_PERIOD_3 12

`define START_HEAD_X 3
`define START_HEAD_Y 3
`define START_FRUIT_X 9
`define START_FRUIT_Y 2

`endif

// File: design/snakePkg.sv
package snakePkg;

	// One grid coordinate, column or row
	typedef logic [4:0] cellCoordT;

	typedef enum logic [1:0] {
		dirUp    = 2'd0,
		dirDown  = 2'd1,
		dirLeft  = 2'd2,
		dirRight = 2'd3
	} dirT;

	// 0 and 1 wrap at the edge, 2 and 3 die there
	typedef logic [1:0] difficultyT;

	typedef logic [2:0] rgbT; // Red is bit 2, blue bit 0

	typedef logic [3:0] bcdDigitT;

	// Digit 0 is the least significant
	typedef bcdDigitT [3:0] scoreT;

	typedef logic [9:0] pixCoordT;

endpackage

// File: design/stepTimer.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module stepTimer (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 newGame,
	input  snakePkg::difficultyT difficulty,
	output logic                 step
);
	import snakePkg::*;

	localparam int CntW = $clog2(`STEP_PERIOD_0); // Period 0 is the longest

	logic [CntW-1:0] cnt;

	function automatic logic [CntW-1:0] reloadOf(input difficultyT d);
		case (d)
			2'd0: reloadOf = CntW'(`STEP_PERIOD_0 - 1);
			2'd1: reloadOf = CntW'(`STEP_PERIOD_1 - 1);
			2'd2: reloadOf = CntW'(`STEP_PERIOD_2 - 1);
			default: reloadOf = CntW'(`STEP_PERIOD_3 - 1);
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rstN || newGame) begin
			cnt  <= reloadOf(difficulty);
			step <= 1'b0;
		end else if (cnt == '0) begin
			cnt  <= reloadOf(difficulty);
			step <= 1'b1;
		end else begin
			cnt  <= cnt - 1'b1;
			step <= 1'b0;
		end
	end

endmodule

// File: design/snakeEngine.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snakeEngine (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 step,
	input  logic                 newGame,
	input  logic                 paused,
	input  snakePkg::difficultyT difficulty,
	input  snakePkg::dirT        moveDir,
	input  snakePkg::cellCoordT  fruitX,
	input  snakePkg::cellCoordT  fruitY,
	output snakePkg::cellCoordT  headX,
	output snakePkg::cellCoordT  headY,
	output snakePkg::cellCoordT  bodyX [0:`MAX_SEGMENTS-1],
	output snakePkg::cellCoordT  bodyY [0:`MAX_SEGMENTS-1],
	output logic [`MAX_SEGMENTS-1:0] bodyValid,
	output snakePkg::cellCoordT  fruitCellX,
	output snakePkg::cellCoordT  fruitCellY,
	output logic                 gameOver,
	output logic                 scoreInc,
	output logic                 scoreClr
);
	import snakePkg::*;

	logic [$clog2(`MAX_SEGMENTS+1)-1:0] length;
	cellCoordT nextX, nextY;
	logic offGrid, wallDeath, hitBody, ateFruit;
	logic restart, moveStep, advance;

	// Candidate head, with wrap applied when the move leaves the grid
	always_comb begin
		nextX   = headX;
		nextY   = headY;
		offGrid = 1'b0;
		case (moveDir)
			dirUp: begin
				offGrid = (headY == '0);
				nextY   = offGrid ? cellCoordT'(`GRID_ROWS - 1) : headY - 1'b1;
			end
			dirDown: begin
				offGrid = (headY == cellCoordT'(`GRID_ROWS - 1));
				nextY   = offGrid ? '0 : headY + 1'b1;
			end
			dirLeft: begin
				offGrid = (headX == '0);
				nextX   = offGrid ? cellCoordT'(`GRID_COLS - 1) : headX - 1'b1;
			end
			default: begin
				offGrid = (headX == cellCoordT'(`GRID_COLS - 1));
				nextX   = offGrid ? '0 : headX + 1'b1;
			end
		endcase
	end

	// Compared against the body before it shifts
	always_comb begin
		hitBody = 1'b0;
		for (int i = 0; i < `MAX_SEGMENTS; i++) begin
			if (bodyValid[i] && bodyX[i] == nextX && bodyY[i] == nextY)
				hitBody = 1'b1;
		end
	end

	assign wallDeath = offGrid && difficulty[1]; // Difficulties 2 and 3
	assign ateFruit  = (nextX == fruitCellX) && (nextY == fruitCellY);
	assign restart   = newGame || (step && gameOver && paused);
	assign moveStep  = step && !newGame && !paused && !gameOver;
	assign advance   = moveStep && !wallDeath && !hitBody;

	always_ff @(posedge clk) begin
		scoreInc <= 1'b0;
		if (!rstN || restart) begin
			headX      <= cellCoordT'(`START_HEAD_X);
			headY      <= cellCoordT'(`START_HEAD_Y);
			fruitCellX <= cellCoordT'(`START_FRUIT_X);
			fruitCellY <= cellCoordT'(`START_FRUIT_Y);
			length     <= '0;
			bodyValid  <= '0;
			gameOver   <= 1'b0;
			scoreClr   <= rstN; // Pulses on restart only
		end else begin
			scoreClr <= 1'b0;
			if (moveStep && (wallDeath || hitBody)) begin
				gameOver <= 1'b1;
			end else if (advance) begin
				headX <= nextX;
				headY <= nextY;
				if (ateFruit) begin
					fruitCellX <= fruitX;
					fruitCellY <= fruitY;
					scoreInc   <= 1'b1;
					if (length < `MAX_SEGMENTS) begin
						bodyValid[length] <= 1'b1; // New tail
						length            <= length + 1'b1;
					end
				end
			end
		end
	end

	// Shift chain, validity lives in bodyValid
	always_ff @(posedge clk) begin
		if (advance) begin
			bodyX[0] <= headX;
			bodyY[0] <= headY;
			for (int i = 1; i < `MAX_SEGMENTS; i++) begin
				bodyX[i] <= bodyX[i-1];
				bodyY[i] <= bodyY[i-1];
			end
		end
	end

endmodule

// File: design/scoreCounter.sv
`timescale 1ns/1ps

module scoreCounter (
	input  logic            clk,
	input  logic            rstN,
	input  logic            inc,
	input  logic            clr,
	output snakePkg::scoreT score
);
	import snakePkg::*;

	scoreT nextScore;
	logic  carry;

	// BCD increment, ripples through digits that sit at 9
	always_comb begin
		nextScore = score;
		carry     = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (carry) begin
				if (score[i] == bcdDigitT'(9)) begin
					nextScore[i] = '0;
				end else begin
					nextScore[i] = score[i] + 1'b1;
					carry        = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN || clr)
			score <= '0; // clr beats inc
		else if (inc)
			score <= nextScore;
	end

endmodule

// File: design/pixelRenderer.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module pixelRenderer (
	input  logic                clk,
	input  logic                rstN,
	input  logic                videoOn,
	input  snakePkg::pixCoordT  pixX,
	input  snakePkg::pixCoordT  pixY,
	input  snakePkg::cellCoordT headX,
	input  snakePkg::cellCoordT headY,
	input  snakePkg::cellCoordT bodyX [0:`MAX_SEGMENTS-1],
	input  snakePkg::cellCoordT bodyY [0:`MAX_SEGMENTS-1],
	input  logic [`MAX_SEGMENTS-1:0] bodyValid,
	input  snakePkg::cellCoordT fruitCellX,
	input  snakePkg::cellCoordT fruitCellY,
	input  logic                gameOver,
	output snakePkg::rgbT       rgb
);
	import snakePkg::*;

	pixCoordT  relX, relY;
	cellCoordT cellX, cellY;
	logic      inField, wall, onHead, onBody, onFruit;
	rgbT       nextRgb;

	assign relX  = pixX - pixCoordT'(`FIELD_ORG_PX);
	assign relY  = pixY - pixCoordT'(`FIELD_ORG_PX);
	assign cellX = cellCoordT'(relX / pixCoordT'(`CELL_PX));
	assign cellY = cellCoordT'(relY / pixCoordT'(`CELL_PX));

	// Cell index is only meaningful inside the field
	assign inField = (pixX >= pixCoordT'(`FIELD_ORG_PX))
		&& (pixX < pixCoordT'(`FIELD_ORG_PX + `CELL_PX * `GRID_COLS))
		&& (pixY >= pixCoordT'(`FIELD_ORG_PX))
		&& (pixY < pixCoordT'(`FIELD_ORG_PX + `CELL_PX * `GRID_ROWS));

	assign wall = (pixX <= pixCoordT'(`WALL_LEFT_MAX))
		|| (pixX >= pixCoordT'(`WALL_RIGHT_MIN) && pixX <= pixCoordT'(`WALL_RIGHT_MAX))
		|| (pixY <= pixCoordT'(`WALL_TOP_MAX))
		|| (pixY >= pixCoordT'(`WALL_BOTTOM_MIN) && pixY <= pixCoordT'(`WALL_BOTTOM_MAX));

	assign onHead  = inField && cellX == headX && cellY == headY;
	assign onFruit = inField && cellX == fruitCellX && cellY == fruitCellY;

	always_comb begin
		onBody = 1'b0;
		for (int i = 0; i < `MAX_SEGMENTS; i++) begin
			if (bodyValid[i] && cellX == bodyX[i] && cellY == bodyY[i])
				onBody = inField;
		end
	end

	always_comb begin
		if (!videoOn)             nextRgb = 3'b000;
		else if (wall)            nextRgb = 3'b111;
		else if (gameOver)        nextRgb = 3'b001; // Steady blue field
		else if (onHead || onBody) nextRgb = 3'b010;
		else if (onFruit)         nextRgb = 3'b100;
		else                      nextRgb = 3'b000;
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			rgb <= '0;
		else
			rgb <= nextRgb;
	end

endmodule

// File: design/snakeGame.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snakeGame (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 newGame,
	input  logic                 paused,
	input  snakePkg::difficultyT difficulty,
	input  snakePkg::dirT        moveDir,
	input  snakePkg::cellCoordT  fruitX,
	input  snakePkg::cellCoordT  fruitY,
	input  logic                 videoOn,
	input  snakePkg::pixCoordT   pixX,
	input  snakePkg::pixCoordT   pixY,
	output snakePkg::rgbT        rgb,
	output snakePkg::scoreT      score,
	output logic                 gameOver
);

	logic step, scoreInc, scoreClr;
	snakePkg::cellCoordT headX, headY, fruitCellX, fruitCellY;
	snakePkg::cellCoordT bodyX [0:`MAX_SEGMENTS-1];
	snakePkg::cellCoordT bodyY [0:`MAX_SEGMENTS-1];
	logic [`MAX_SEGMENTS-1:0] bodyValid;

	stepTimer uTimer (
		.clk(clk), .rstN(rstN), .newGame(newGame), .difficulty(difficulty), .step(step)
	);

	snakeEngine uEngine (
		.clk(clk), .rstN(rstN), .step(step), .newGame(newGame), .paused(paused),
		.difficulty(difficulty), .moveDir(moveDir), .fruitX(fruitX), .fruitY(fruitY),
		.headX(headX), .headY(headY), .bodyX(bodyX), .bodyY(bodyY),
		.bodyValid(bodyValid), .fruitCellX(fruitCellX), .fruitCellY(fruitCellY),
		.gameOver(gameOver), .scoreInc(scoreInc), .scoreClr(scoreClr)
	);

	// Lags the engine by one clock
	scoreCounter uScore (
		.clk(clk), .rstN(rstN), .inc(scoreInc), .clr(scoreClr), .score(score)
	);

	pixelRenderer uRender (
		.clk(clk), .rstN(rstN), .videoOn(videoOn), .pixX(pixX), .pixY(pixY),
		.headX(headX), .headY(headY), .bodyX(bodyX), .bodyY(bodyY),
		.bodyValid(bodyValid), .fruitCellX(fruitCellX), .fruitCellY(fruitCellY),
		.gameOver(gameOver), .rgb(rgb)
	);

endmodule

// File: verif/snakeGame_assert.sv
`timescale 1ns/1ps

module snakeGame_assert (
	input logic            clk,
	input logic            rstN,
	input logic            newGame,
	input logic            paused,
	input logic            step,
	input logic            videoOn,
	input snakePkg::rgbT   rgb,
	input snakePkg::scoreT score,
	input logic            gameOver
);
	int errCount = 0;

	// Renderer is one register deep
	blankRgb: assert property (@(posedge clk) disable iff (!rstN)
		!videoOn |=> rgb == 3'b000)
		else begin
			errCount++;
			$error("rgb not black one cycle after blanking");
		end

	bcdDigits: assert property (@(posedge clk) disable iff (!rstN)
		score[0] <= 4'd9 && score[1] <= 4'd9 && score[2] <= 4'd9 && score[3] <= 4'd9)
		else begin
			errCount++;
			$error("score digit above 9");
		end

	overHolds: assert property (@(posedge clk) disable iff (!rstN)
		gameOver && !newGame && !(step && paused) |=> gameOver)
		else begin
			errCount++;
			$error("gameOver dropped without a restart");
		end

	stepSingle: assert property (@(posedge clk) disable iff (!rstN) step |=> !step)
		else begin
			errCount++;
			$error("step high on two cycles in a row");
		end

endmodule

bind snakeGame snakeGame_assert uAssert (
	.clk(clk), .rstN(rstN), .newGame(newGame), .paused(paused), .step(step),
	.videoOn(videoOn), .rgb(rgb), .score(score), .gameOver(gameOver)
);

// File: verif/snakeGame_tb.sv
`timescale 1ns/1ps
`include "snake_cfg.svh"

module snakeGame_tb;
	import snakePkg::*;

	localparam int TotalSteps = 2700;
	localparam int CycleLimit = TotalSteps * `STEP_PERIOD_0 + 2000;

	logic clk = 1'b0;
	logic rstN, newGame, paused, videoOn, gameOver;
	difficultyT difficulty;
	dirT moveDir;
	cellCoordT fruitX, fruitY;
	pixCoordT pixX, pixY;
	rgbT rgb;
	scoreT score;

	// Reference model of the game
	int mHeadX, mHeadY, mFruitX, mFruitY, mLen, mScore, lastDir, sinceRef, period;
	int mBodyX [`MAX_SEGMENTS];
	int mBodyY [`MAX_SEGMENTS];
	logic mOver, pendInc, pendClr, stepHigh;
	rgbT expRgb;

	logic [31:0] lfsr = 32'h0c19_d4bc;
	logic ngReq;
	int steer, overHold, overWait, pauseLeft, stepCount;
	int cycles = 0;

	snakeGame u_snakeGame (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > CycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic logic nextBit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003; // Taps 32, 22, 2, 1
		return b;
	endfunction

	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(nextBit());
		return v;
	endfunction

	function automatic int periodOf(input difficultyT d);
		case (d)
			2'd0: return `STEP_PERIOD_0;
			2'd1: return `STEP_PERIOD_1;
			2'd2: return `STEP_PERIOD_2;
			default: return `STEP_PERIOD_3;
		endcase
	endfunction

	function automatic scoreT toBcd(input int v);
		scoreT s;
		for (int i = 0; i < 4; i++) begin
			s[i] = bcdDigitT'(v % 10);
			v = v / 10;
		end
		return s;
	endfunction

	// Some pixel inside cell c on either axis
	function automatic int cellPix(input int c);
		return `FIELD_ORG_PX + `CELL_PX * c + randBits(5) % `CELL_PX;
	endfunction

	function automatic rgbT expectColour(input logic vid, input int x, input int y);
		int cx, cy;
		logic inField, onSnake;
		inField = x >= `FIELD_ORG_PX && x < `FIELD_ORG_PX + `CELL_PX * `GRID_COLS
			&& y >= `FIELD_ORG_PX && y < `FIELD_ORG_PX + `CELL_PX * `GRID_ROWS;
		cx = (x - `FIELD_ORG_PX) / `CELL_PX;
		cy = (y - `FIELD_ORG_PX) / `CELL_PX;
		onSnake = inField && cx == mHeadX && cy == mHeadY;
		for (int i = 0; i < mLen; i++)
			if (inField && cx == mBodyX[i] && cy == mBodyY[i])
				onSnake = 1'b1;
		if (!vid)
			return 3'b000;
		else if (x <= `WALL_LEFT_MAX || (x >= `WALL_RIGHT_MIN && x <= `WALL_RIGHT_MAX)
			|| y <= `WALL_TOP_MAX || (y >= `WALL_BOTTOM_MIN && y <= `WALL_BOTTOM_MAX))
			return 3'b111;
		else if (mOver)
			return 3'b001;
		else if (onSnake)
			return 3'b010;
		else if (inField && cx == mFruitX && cy == mFruitY)
			return 3'b100;
		return 3'b000;
	endfunction

	// Greedy toward the fruit and never straight back over segment 0
	function automatic dirT chooseDir();
		int d;
		if (steer == 1)
			return dirUp;
		if (steer == 3)
			return dirT'(lastDir ^ 1);
		if (steer == 0 && randBits(4) == 0)
			return dirT'(randBits(2));
		if (mFruitX > mHeadX)
			d = 3;
		else if (mFruitX < mHeadX)
			d = 2;
		else if (mFruitY > mHeadY)
			d = 1;
		else
			d = 0;
		if (mLen > 0 && d == (lastDir ^ 1))
			d = d ^ 2;
		return dirT'(d);
	endfunction

	task automatic checkScore(input scoreT exp);
		if (score !== exp) begin
			$display("Error at %0t ns: score %h, expected %h", $time, score, exp);
			$display("TEST FAILED");
			$fatal(1, "score mismatch");
		end
	endtask

	task automatic checkFlag(input logic exp);
		if (gameOver !== exp) begin
			$display("Error at %0t ns: gameOver %b, expected %b", $time, gameOver, exp);
			$display("TEST FAILED");
			$fatal(1, "gameOver mismatch");
		end
	endtask

	task automatic checkRgb(input rgbT exp);
		if (rgb !== exp) begin
			$display("Error at %0t ns: rgb %b, expected %b", $time, rgb, exp);
			$display("TEST FAILED");
			$fatal(1, "rgb mismatch");
		end
	endtask

	task automatic resetGame();
		mHeadX = `START_HEAD_X;
		mHeadY = `START_HEAD_Y;
		mFruitX = `START_FRUIT_X;
		mFruitY = `START_FRUIT_Y;
		mLen = 0;
		mOver = 1'b0;
	endtask

	task automatic applyStep();
		int nx, ny;
		logic off, hit;
		nx = mHeadX;
		ny = mHeadY;
		if (mOver && paused) begin
			resetGame();
			pendClr = 1'b1;
		end else if (!mOver && !paused) begin
			case (moveDir)
				dirUp: ny--;
				dirDown: ny++;
				dirLeft: nx--;
				default: nx++;
			endcase
			off = nx < 0 || nx >= `GRID_COLS || ny < 0 || ny >= `GRID_ROWS;
			nx = (nx + `GRID_COLS) % `GRID_COLS;
			ny = (ny + `GRID_ROWS) % `GRID_ROWS;
			hit = 1'b0;
			for (int i = 0; i < mLen; i++)
				if (mBodyX[i] == nx && mBodyY[i] == ny)
					hit = 1'b1; // Body before the shift
			if ((off && difficulty >= 2'd2) || hit) begin
				mOver = 1'b1;
			end else begin
				for (int i = `MAX_SEGMENTS - 1; i > 0; i--) begin
					mBodyX[i] = mBodyX[i-1];
					mBodyY[i] = mBodyY[i-1];
				end
				mBodyX[0] = mHeadX;
				mBodyY[0] = mHeadY;
				mHeadX = nx;
				mHeadY = ny;
				lastDir = int'(moveDir);
				if (nx == mFruitX && ny == mFruitY) begin
					mFruitX = fruitX;
					mFruitY = fruitY;
					pendInc = 1'b1;
					if (mLen < `MAX_SEGMENTS)
						mLen++;
				end
			end
		end
	endtask

	// One rising edge of the model with the inputs driven this cycle
	task automatic tickModel();
		if (pendClr)
			mScore = 0;
		else if (pendInc)
			mScore = (mScore + 1) % 10000;
		pendClr = 1'b0;
		pendInc = 1'b0;
		if (newGame) begin
			resetGame();
			pendClr = 1'b1;
			period = periodOf(difficulty);
			sinceRef = 0;
			stepHigh = 1'b0;
		end else begin
			if (stepHigh)
				applyStep();
			sinceRef++;
			stepHigh = (sinceRef % period == 0);
		end
	endtask

	task automatic runCycle();
		int sel, idx, cx, cy;
		checkScore(toBcd(mScore));
		checkFlag(mOver);
		checkRgb(expRgb);
		newGame = ngReq;
		fruitX = cellCoordT'(randBits(5) % `GRID_COLS);
		fruitY = cellCoordT'(randBits(5) % `GRID_ROWS);
		if (stepHigh && !ngReq) begin
			stepCount++;
			if (mOver) begin
				if (overWait > 0) begin
					overWait--;
					paused = 1'b0;
				end else if (nextBit()) begin
					paused = 1'b1; // Restart by a paused step
				end else begin
					newGame = 1'b1;
				end
			end else begin
				overWait = overHold;
				paused = (pauseLeft > 0);
				if (pauseLeft > 0)
					pauseLeft--;
				else if (randBits(5) == 0)
					pauseLeft = 1 + randBits(2);
				moveDir = chooseDir();
			end
		end
		sel = randBits(2);
		videoOn = (randBits(3) != 0);
		cx = mHeadX;
		cy = mHeadY;
		if (sel == 1 && mLen > 0) begin
			idx = randBits(4) % mLen;
			cx = mBodyX[idx];
			cy = mBodyY[idx];
		end else if (sel == 2) begin
			cx = mFruitX;
			cy = mFruitY;
		end
		if (sel == 3) begin
			pixX = pixCoordT'(randBits(10) % 640);
			pixY = pixCoordT'(randBits(9) % 480);
		end else begin
			pixX = pixCoordT'(cellPix(cx));
			pixY = pixCoordT'(cellPix(cy));
		end
		expRgb = expectColour(videoOn, int'(pixX), int'(pixY)); // Old state as seen at this edge
		tickModel();
		@(negedge clk);
	endtask

	task automatic playSteps(input int n, input int mode);
		int target;
		target = stepCount + n;
		steer = mode;
		while (stepCount < target)
			runCycle();
	endtask

	task automatic startGame(input difficultyT d);
		ngReq = 1'b1;
		difficulty = d;
		runCycle();
		ngReq = 1'b0;
	endtask

	initial begin
		rstN = 1'b0;
		newGame = 1'b0;
		paused = 1'b0;
		difficulty = 2'd0;
		moveDir = dirUp;
		fruitX = '0;
		fruitY = '0;
		videoOn = 1'b0;
		pixX = '0;
		pixY = '0;
		ngReq = 1'b0;
		steer = 0;
		overHold = 2;
		overWait = 2;
		pauseLeft = 0;
		stepCount = 0;
		resetGame();
		mScore = 0;
		pendInc = 1'b0;
		pendClr = 1'b0;
		stepHigh = 1'b0;
		sinceRef = 0;
		period = periodOf(2'd0);
		expRgb = 3'b000;
		lastDir = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		playSteps(400, 0); // Wrapping walks
		overHold = 8;
		startGame(2'd3);
		playSteps(12, 1); // Top wall on the fourth move
		overHold = 2;
		playSteps(20, 0);
		repeat (6) begin
			startGame(difficultyT'(randBits(2)));
			playSteps(200 + randBits(7), 0);
		end
		startGame(2'd1);
		playSteps(300, 2);
		playSteps(1, 3); // Back onto segment 0
		playSteps(4, 0);

		// Results of the last modelled edge
		checkScore(toBcd(mScore));
		checkFlag(mOver);
		checkRgb(expRgb);

		if (u_snakeGame.uAssert.errCount == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("Assertion failures were reported during the run");
			$display("TEST FAILED");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// File: all.f
+incdir+include
design/snakePkg.sv
design/stepTimer.sv
design/snakeEngine.sv
design/scoreCounter.sv
design/pixelRenderer.sv
design/snakeGame.sv
verif/snakeGame_assert.sv
verif/snakeGame_tb.sv

// File: Makefile
TOP = snakeGame_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
